/* verilog.f */
+incdir+tests
common/dma_pkg.sv
hdl/slave_regs.sv
master/master_regs.sv
master/master_cmd_fsm.sv
hdl/capture_fifo.sv
hdl/dma_top.sv
tests/tb_dma_top.sv

/* Makefile */
# Verilator build and run of the DMA user logic testbench

.PHONY: help test clean

help:
	@echo "make test   build tb_dma_top with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_dma_top \
		-f verilog.f --Mdir obj_dir -o tb_dma_top
	./obj_dir/tb_dma_top

clean:
	rm -rf obj_dir

/* tests/tb_dma_tasks.svh */
`ifndef TB_DMA_TASKS_SVH
`define TB_DMA_TASKS_SVH

// ----------------------------------------------------------
// error reporting and compares
// ----------------------------------------------------------
task automatic fail_run(input string msg);
  $display("%s", msg);
  $display("TESTBENCH FAILED");
  $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
  if (got !== exp)
    fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_be(input string name, input be_t got, input be_t exp);
  if (got !== exp)
    fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
    fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

// ----------------------------------------------------------
// chip enables and register access
// ----------------------------------------------------------
// bit 7 picks slave register 0
function automatic ce_t slv_ce(input int idx);
  ce_t ce;
  ce = '0;
  ce[NUM_SLV_REG-1-idx] = 1'b1;
  return ce;
endfunction

// bit 11 picks master word 0
function automatic ce_t mst_ce(input int idx);
  ce_t ce;
  ce = '0;
  ce[NUM_CE-1-idx] = 1'b1;
  return ce;
endfunction

// expected word 0, busy always low where this is used
function automatic word_t status_word(input logic [7:0] cntl, input logic done,
                                      input logic error, input logic timeout);
  logic [7:0] stat;
  stat                   = '0;
  stat[STAT_DONE_BIT]    = done;
  stat[STAT_ERROR_BIT]   = error;
  stat[STAT_TIMEOUT_BIT] = timeout;
  return {16'h0, stat, cntl};
endfunction

task automatic bus_write(input ce_t ce, input be_t be, input word_t data);
  @(negedge Bus2IP_Clk);
  bus2ip_wrce = ce;
  bus2ip_be   = be;
  bus2ip_data = data;
  #(SETTLE_NS);
  check_bit("ip2bus_wrack", ip2bus_wrack, 1'b1);
  @(negedge Bus2IP_Clk);
  bus2ip_wrce = '0;
endtask

task automatic bus_read(input ce_t ce, output word_t data);
  @(negedge Bus2IP_Clk);
  bus2ip_rdce = ce;
  #(SETTLE_NS);
  check_bit("ip2bus_rdack", ip2bus_rdack, 1'b1);
  data = ip2bus_data;
  @(negedge Bus2IP_Clk);
  bus2ip_rdce = '0;
endtask

// ----------------------------------------------------------
// master command helpers
// ----------------------------------------------------------
task automatic start_go();
  bus_write(mst_ce(3), 4'b1000, {GO_DATA_KEY, 24'h0});
endtask

// returns on the falling edge where the request is seen
task automatic wait_request(input logic want_wr);
  int   cycles;
  logic seen;
  cycles = 0;
  seen   = 1'b0;
  while (!seen && cycles < REQ_TIMEOUT)
  begin
    @(negedge Bus2IP_Clk);
    seen = want_wr ? ip2bus_mstwr_req : ip2bus_mstrd_req;
    cycles++;
  end
  if (!seen)
    fail_run("timed out waiting for the master request");
endtask

// one cycle of master bus responses
task automatic pulse_master(input logic cmdack, input logic cmplt,
                            input logic err, input logic tmo);
  @(negedge Bus2IP_Clk);
  bus2ip_mst_cmdack      = cmdack;
  bus2ip_mst_cmplt       = cmplt;
  bus2ip_mst_error       = err;
  bus2ip_mst_cmd_timeout = tmo;
  @(negedge Bus2IP_Clk);
  bus2ip_mst_cmdack      = 1'b0;
  bus2ip_mst_cmplt       = 1'b0;
  bus2ip_mst_error       = 1'b0;
  bus2ip_mst_cmd_timeout = 1'b0;
endtask

// poll word 0 until the status busy bit drops
task automatic wait_idle(output word_t stat);
  int    polls;
  word_t got;
  polls = 0;
  bus_read(mst_ce(0), got);
  while (got[8+STAT_BUSY_BIT] && polls < POLL_LIMIT)
  begin
    bus_read(mst_ce(0), got);
    polls++;
  end
  if (got[8+STAT_BUSY_BIT])
    fail_run("status busy never cleared after the master command");
  stat = got;
endtask

// ----------------------------------------------------------
// capture fifo helpers
// ----------------------------------------------------------
task automatic push_words(input int count);
  word_t w;
  for (int i = 0; i < count; i++)
  begin
    w = lfsr_word();
    // words pushed into a full fifo are lost
    if (fifo_model.size() < FIFO_DEPTH_DEFAULT)
      fifo_model.push_back(w);
    @(negedge Bus2IP_Clk);
    bus2ip_mstrd_d         = w;
    bus2ip_mstrd_src_rdy_n = 1'b0;
  end
  @(negedge Bus2IP_Clk);
  bus2ip_mstrd_src_rdy_n = 1'b1;
endtask

task automatic pop_words(input int count);
  word_t exp;
  for (int i = 0; i < count; i++)
  begin
    @(negedge Bus2IP_Clk);
    exp = fifo_model.pop_front();
    check_word("ip2bus_mstwr_d", ip2bus_mstwr_d, exp);
    bus2ip_mstwr_dst_rdy_n = 1'b0;
  end
  @(negedge Bus2IP_Clk);
  bus2ip_mstwr_dst_rdy_n = 1'b1;
endtask

// ----------------------------------------------------------
// directed tests
// ----------------------------------------------------------
task automatic reset_values();
  word_t got;
  for (int i = 0; i < NUM_SLV_REG; i++)
  begin
    bus_read(slv_ce(i), got);
    check_word($sformatf("slave reg %0d after reset", i), got, '0);
  end
  // word 0 carries the status byte
  for (int w = 0; w < NUM_MST_WORD; w++)
  begin
    bus_read(mst_ce(w), got);
    check_word($sformatf("master word %0d after reset", w), got, '0);
  end
  check_bit("ip2bus_mstrd_req", ip2bus_mstrd_req, 1'b0);
  check_bit("ip2bus_mstwr_req", ip2bus_mstwr_req, 1'b0);
  check_bit("ip2bus_mst_lock", ip2bus_mst_lock, 1'b0);
endtask

task automatic slave_scratch();
  word_t exp [NUM_SLV_REG];
  word_t got;
  for (int i = 0; i < NUM_SLV_REG; i++)
  begin
    exp[i] = lfsr_word();
    bus_write(slv_ce(i), 4'hF, exp[i]);
  end
  for (int i = 0; i < NUM_SLV_REG; i++)
  begin
    bus_read(slv_ce(i), got);
    check_word($sformatf("slave reg %0d", i), got, exp[i]);
  end
  // two enables at once select nothing
  bus_read(slv_ce(0) | slv_ce(5), got);
  check_word("slave read with two enables", got, '0);
endtask

task automatic master_byte_lanes();
  word_t first;
  word_t second;
  word_t exp;
  word_t got;
  be_t   lanes;
  first  = lfsr_word();
  second = lfsr_word();
  lanes  = 4'b0101;
  bus_write(mst_ce(1), 4'hF, first);
  bus_write(mst_ce(1), lanes, second);
  for (int k = 0; k < BE_WIDTH; k++)
    exp[k*8 +: 8] = lanes[k] ? second[k*8 +: 8] : first[k*8 +: 8];
  bus_read(mst_ce(1), got);
  check_word("address word after partial write", got, exp);
  // 12 bit length, byte 14 reserved, go byte write only
  bus_write(mst_ce(3), 4'hF, 32'hFFFF_FFFF);
  bus_read(mst_ce(3), got);
  check_word("length word", got, 32'h0000_0FFF);
  // wrong key must not start a read request
  bus_write(mst_ce(0), 4'b0001, 32'h0000_0001);
  bus_write(mst_ce(3), 4'b1000, {GO_DATA_KEY ^ 8'h01, 24'h0});
  repeat (16)
  begin
    @(negedge Bus2IP_Clk);
    check_bit("ip2bus_mstrd_req after wrong key", ip2bus_mstrd_req, 1'b0);
  end
  bus_read(mst_ce(0), got);
  check_word("status after wrong key", got, status_word(8'h01, 1'b0, 1'b0, 1'b0));
endtask

task automatic read_command();
  addr_t      addr;
  be_t        bev;
  word_t      got;
  logic [7:0] cntl;
  cntl                    = '0;
  cntl[CNTL_RD_REQ_BIT]   = 1'b1;
  cntl[CNTL_BUS_LOCK_BIT] = 1'b1;
  addr                    = lfsr_word();
  bev                     = lfsr_be();
  bus_write(mst_ce(0), 4'b0001, {24'h0, cntl});
  bus_write(mst_ce(1), 4'hF, addr);
  // be sits in the top nibble of bytes 8 and 9
  bus_write(mst_ce(2), 4'b0011, {16'h0, bev, 12'h0});
  start_go();
  wait_request(1'b0);
  check_word("ip2bus_mst_addr", ip2bus_mst_addr, addr);
  check_be("ip2bus_mst_be", ip2bus_mst_be, bev);
  check_bit("ip2bus_mst_lock", ip2bus_mst_lock, 1'b1);
  check_bit("ip2bus_mstwr_req", ip2bus_mstwr_req, 1'b0);
  pulse_master(1'b1, 1'b0, 1'b0, 1'b0);
  check_bit("ip2bus_mstrd_req after cmdack", ip2bus_mstrd_req, 1'b0);
  pulse_master(1'b0, 1'b1, 1'b0, 1'b0);
  wait_idle(got);
  check_word("status after read command", got, status_word(cntl, 1'b1, 1'b0, 1'b0));
endtask

task automatic error_and_timeout();
  word_t      got;
  logic [7:0] cntl;
  cntl                  = '0;
  cntl[CNTL_WR_REQ_BIT] = 1'b1;
  // control and status together, done from the last command goes
  bus_write(mst_ce(0), 4'b0011, {24'h0, cntl});
  start_go();
  wait_request(1'b1);
  check_bit("ip2bus_mst_lock", ip2bus_mst_lock, 1'b0);
  pulse_master(1'b0, 1'b1, 1'b0, 1'b1);
  wait_idle(got);
  check_word("status after timeout", got, status_word(cntl, 1'b1, 1'b1, 1'b1));
  bus_write(mst_ce(0), 4'b0010, '0);
  bus_read(mst_ce(0), got);
  check_word("status after clear", got, status_word(cntl, 1'b0, 1'b0, 1'b0));
  // second command ends with a bus error
  start_go();
  wait_request(1'b1);
  pulse_master(1'b1, 1'b0, 1'b0, 1'b0);
  pulse_master(1'b0, 1'b1, 1'b1, 1'b0);
  wait_idle(got);
  check_word("status after error", got, status_word(cntl, 1'b1, 1'b1, 1'b0));
  bus_write(mst_ce(0), 4'b0010, '0);
  bus_read(mst_ce(0), got);
  check_word("status after second clear", got, status_word(cntl, 1'b0, 1'b0, 1'b0));
endtask

task automatic fifo_capture();
  push_words(5);
  pop_words(5);
  // two words past full are dropped
  push_words(FIFO_DEPTH_DEFAULT + 2);
  pop_words(FIFO_DEPTH_DEFAULT);
  // a fresh word proves the fifo drained empty
  push_words(1);
  pop_words(1);
endtask

`endif

/* tests/tb_dma_top.sv */
`default_nettype none

module tb_dma_top
  import dma_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] LFSR_SEED   = 32'h9f0a5dae;
  localparam logic [31:0] LFSR_TAPS   = 32'h80200003;
  // combinational outputs are sampled this long after a falling edge drive
  localparam int          SETTLE_NS   = 2;
  localparam int          REQ_TIMEOUT = 32;
  localparam int          POLL_LIMIT  = 32;
  localparam int          WATCHDOG_NS = 200000;

  logic  Bus2IP_Clk;
  logic  rst_n;
  word_t bus2ip_data;
  be_t   bus2ip_be;
  ce_t   bus2ip_rdce;
  ce_t   bus2ip_wrce;
  word_t ip2bus_data;
  logic  ip2bus_rdack;
  logic  ip2bus_wrack;
  logic  bus2ip_mst_cmdack;
  logic  bus2ip_mst_cmplt;
  logic  bus2ip_mst_error;
  logic  bus2ip_mst_cmd_timeout;
  word_t bus2ip_mstrd_d;
  logic  bus2ip_mstrd_src_rdy_n;
  logic  bus2ip_mstwr_dst_rdy_n;
  logic  ip2bus_mstrd_req;
  logic  ip2bus_mstwr_req;
  logic  ip2bus_mst_lock;
  addr_t ip2bus_mst_addr;
  be_t   ip2bus_mst_be;
  word_t ip2bus_mstwr_d;

  logic [31:0] lfsr_state;
  // expected capture fifo contents, oldest at the front
  word_t       fifo_model [$];

  dma_top #(
    .fifo_depth (FIFO_DEPTH_DEFAULT)
  ) dut0 (
    .Bus2IP_Clk             (Bus2IP_Clk),
    .rst_n                  (rst_n),
    .bus2ip_data            (bus2ip_data),
    .bus2ip_be              (bus2ip_be),
    .bus2ip_rdce            (bus2ip_rdce),
    .bus2ip_wrce            (bus2ip_wrce),
    .ip2bus_data            (ip2bus_data),
    .ip2bus_rdack           (ip2bus_rdack),
    .ip2bus_wrack           (ip2bus_wrack),
    .bus2ip_mst_cmdack      (bus2ip_mst_cmdack),
    .bus2ip_mst_cmplt       (bus2ip_mst_cmplt),
    .bus2ip_mst_error       (bus2ip_mst_error),
    .bus2ip_mst_cmd_timeout (bus2ip_mst_cmd_timeout),
    .bus2ip_mstrd_d         (bus2ip_mstrd_d),
    .bus2ip_mstrd_src_rdy_n (bus2ip_mstrd_src_rdy_n),
    .bus2ip_mstwr_dst_rdy_n (bus2ip_mstwr_dst_rdy_n),
    .ip2bus_mstrd_req       (ip2bus_mstrd_req),
    .ip2bus_mstwr_req       (ip2bus_mstwr_req),
    .ip2bus_mst_lock        (ip2bus_mst_lock),
    .ip2bus_mst_addr        (ip2bus_mst_addr),
    .ip2bus_mst_be          (ip2bus_mst_be),
    .ip2bus_mstwr_d         (ip2bus_mstwr_d)
  );

  // ----------------------------------------------------------
  // galois lfsr, one step per bit taken
  // ----------------------------------------------------------
  function automatic logic next_lfsr_bit();
    logic lsb;
    lsb        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb)
      lfsr_state = lfsr_state ^ LFSR_TAPS;
    return lsb;
  endfunction

  function automatic word_t lfsr_word();
    word_t w;
    w = '0;
    for (int i = 0; i < DWIDTH; i++)
      w = {w[DWIDTH-2:0], next_lfsr_bit()};
    return w;
  endfunction

  function automatic be_t lfsr_be();
    be_t b;
    b = '0;
    for (int i = 0; i < BE_WIDTH; i++)
      b = {b[BE_WIDTH-2:0], next_lfsr_bit()};
    return b;
  endfunction

  `include "tb_dma_tasks.svh"

  // 10 ns clock
  initial
  begin
    Bus2IP_Clk = 1'b0;
    forever
      #5 Bus2IP_Clk = ~Bus2IP_Clk;
  end

  // last line of defence against a stuck run
  initial
  begin
    #(WATCHDOG_NS);
    fail_run("watchdog expired before the test sequence finished");
  end

  initial
  begin
    lfsr_state             = LFSR_SEED;
    rst_n                  = 1'b0;
    bus2ip_data            = '0;
    bus2ip_be              = '0;
    bus2ip_rdce            = '0;
    bus2ip_wrce            = '0;
    bus2ip_mst_cmdack      = 1'b0;
    bus2ip_mst_cmplt       = 1'b0;
    bus2ip_mst_error       = 1'b0;
    bus2ip_mst_cmd_timeout = 1'b0;
    bus2ip_mstrd_d         = '0;
    bus2ip_mstrd_src_rdy_n = 1'b1;
    bus2ip_mstwr_dst_rdy_n = 1'b1;
    // three rising edges in reset, release on a falling edge
    repeat (3) @(negedge Bus2IP_Clk);
    rst_n = 1'b1;

    reset_values();
    slave_scratch();
    master_byte_lanes();
    read_command();
    error_and_timeout();
    fifo_capture();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/dma_top.sv */
`default_nettype none

module dma_top
  import dma_pkg::*;
#(
  parameter int fifo_depth = FIFO_DEPTH_DEFAULT
)
(
  input  logic  Bus2IP_Clk,
  input  logic  rst_n,
  input  word_t bus2ip_data,
  input  be_t   bus2ip_be,
  input  ce_t   bus2ip_rdce,
  input  ce_t   bus2ip_wrce,
  output word_t ip2bus_data,
  output logic  ip2bus_rdack,
  output logic  ip2bus_wrack,
  input  logic  bus2ip_mst_cmdack,
  input  logic  bus2ip_mst_cmplt,
  input  logic  bus2ip_mst_error,
  input  logic  bus2ip_mst_cmd_timeout,
  input  word_t bus2ip_mstrd_d,
  input  logic  bus2ip_mstrd_src_rdy_n,
  input  logic  bus2ip_mstwr_dst_rdy_n,
  output logic  ip2bus_mstrd_req,
  output logic  ip2bus_mstwr_req,
  output logic  ip2bus_mst_lock,
  output addr_t ip2bus_mst_addr,
  output be_t   ip2bus_mst_be,
  output word_t ip2bus_mstwr_d
);

  word_t slv_rd_data;
  word_t mst_rd_data;
  logic  go;
  logic  cntl_rd_req;
  logic  cntl_wr_req;
  logic  cntl_bus_lock;
  addr_t target_addr;
  be_t   target_be;
  logic  busy;
  logic  clr_go;
  logic  set_done;
  logic  set_error;
  logic  set_timeout;

  // ----------------------------------------------------------
  // register access, ce split between slave and master banks
  // ----------------------------------------------------------
  slave_regs u_slave_regs (
    .Bus2IP_Clk (Bus2IP_Clk),
    .rst_n      (rst_n),
    .wr_sel     (bus2ip_wrce[NUM_SLV_REG-1:0]),
    .rd_sel     (bus2ip_rdce[NUM_SLV_REG-1:0]),
    .wr_data    (bus2ip_data),
    .rd_data    (slv_rd_data)
  );

  master_regs u_master_regs (
    .Bus2IP_Clk    (Bus2IP_Clk),
    .rst_n         (rst_n),
    .wr_sel        (bus2ip_wrce[NUM_CE-1:NUM_SLV_REG]),
    .rd_sel        (bus2ip_rdce[NUM_CE-1:NUM_SLV_REG]),
    .wr_be         (bus2ip_be),
    .wr_data       (bus2ip_data),
    .rd_data       (mst_rd_data),
    .busy          (busy),
    .clr_go        (clr_go),
    .set_done      (set_done),
    .set_error     (set_error),
    .set_timeout   (set_timeout),
    .go            (go),
    .cntl_rd_req   (cntl_rd_req),
    .cntl_wr_req   (cntl_wr_req),
    .cntl_bus_lock (cntl_bus_lock),
    .target_addr   (target_addr),
    .target_be     (target_be)
  );

  // acks come back in the strobe cycle
  assign ip2bus_wrack = |bus2ip_wrce;
  assign ip2bus_rdack = |bus2ip_rdce;

  // slave bank has priority on read data
  assign ip2bus_data = (|bus2ip_rdce[NUM_SLV_REG-1:0])      ? slv_rd_data :
                       (|bus2ip_rdce[NUM_CE-1:NUM_SLV_REG]) ? mst_rd_data : '0;

  // ----------------------------------------------------------
  // master command path and data capture
  // ----------------------------------------------------------
  master_cmd_fsm u_master_cmd_fsm (
    .Bus2IP_Clk      (Bus2IP_Clk),
    .rst_n           (rst_n),
    .go              (go),
    .cntl_rd_req     (cntl_rd_req),
    .cntl_wr_req     (cntl_wr_req),
    .cntl_bus_lock   (cntl_bus_lock),
    .target_addr     (target_addr),
    .target_be       (target_be),
    .mst_cmdack      (bus2ip_mst_cmdack),
    .mst_cmplt       (bus2ip_mst_cmplt),
    .mst_error       (bus2ip_mst_error),
    .mst_cmd_timeout (bus2ip_mst_cmd_timeout),
    .mstrd_req       (ip2bus_mstrd_req),
    .mstwr_req       (ip2bus_mstwr_req),
    .mst_lock        (ip2bus_mst_lock),
    .mst_addr        (ip2bus_mst_addr),
    .mst_be          (ip2bus_mst_be),
    .busy            (busy),
    .clr_go          (clr_go),
    .set_done        (set_done),
    .set_error       (set_error),
    .set_timeout     (set_timeout)
  );

  // ready flags are active low levels
  capture_fifo #(
    .depth (fifo_depth)
  ) u_capture_fifo (
    .Bus2IP_Clk (Bus2IP_Clk),
    .rst_n      (rst_n),
    .push       (!bus2ip_mstrd_src_rdy_n),
    .pop        (!bus2ip_mstwr_dst_rdy_n),
    .din        (bus2ip_mstrd_d),
    .dout       (ip2bus_mstwr_d)
  );

endmodule

`default_nettype wire

/* hdl/capture_fifo.sv */
`default_nettype none

module capture_fifo
  import dma_pkg::*;
#(
  parameter int depth = FIFO_DEPTH_DEFAULT
)
(
  input  logic  Bus2IP_Clk,
  input  logic  rst_n,
  input  logic  push,
  input  logic  pop,
  input  word_t din,
  output word_t dout
);

  localparam int CNT_W = $clog2(depth + 1);
  localparam int IDX_W = $clog2(depth);

  word_t            mem [depth];
  logic [CNT_W-1:0] cnt;
  logic [IDX_W-1:0] rd_idx;
  logic             full;
  logic             empty;
  logic             push_ok;
  logic             pop_ok;

  assign full  = (cnt == CNT_W'(depth));
  assign empty = (cnt == '0);

  // a push into a full fifo is lost
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;

  // ----------------------------------------------------------
  // shift chain, newest word at index 0
  // ----------------------------------------------------------
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (push_ok)
    begin
      mem[0] <= din;
      for (int i = 1; i < depth; i++)
        mem[i] <= mem[i-1];
    end
  end

  // occupancy, push and pop together leave it unchanged
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (!rst_n)
      cnt <= '0;
    else if (push_ok && !pop_ok)
      cnt <= cnt + 1'b1;
    else if (pop_ok && !push_ok)
      cnt <= cnt - 1'b1;
  end

  // oldest word sits at cnt-1
  assign rd_idx = empty ? '0 : IDX_W'(cnt - 1'b1);
  assign dout   = mem[rd_idx];

  a_cnt_in_range : assert property (
    @(posedge Bus2IP_Clk) disable iff (!rst_n)
    cnt <= CNT_W'(depth));

endmodule

`default_nettype wire

/* master/master_cmd_fsm.sv */
`default_nettype none

module master_cmd_fsm
  import dma_pkg::*;
(
  input  logic  Bus2IP_Clk,
  input  logic  rst_n,
  input  logic  go,
  input  logic  cntl_rd_req,
  input  logic  cntl_wr_req,
  input  logic  cntl_bus_lock,
  input  addr_t target_addr,
  input  be_t   target_be,
  input  logic  mst_cmdack,
  input  logic  mst_cmplt,
  input  logic  mst_error,
  input  logic  mst_cmd_timeout,
  output logic  mstrd_req,
  output logic  mstwr_req,
  output logic  mst_lock,
  output addr_t mst_addr,
  output be_t   mst_be,
  output logic  busy,
  output logic  clr_go,
  output logic  set_done,
  output logic  set_error,
  output logic  set_timeout
);

  cmd_state_e state;

  // ----------------------------------------------------------
  // command state machine, every output registered
  // ----------------------------------------------------------
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (!rst_n)
    begin
      state       <= CMD_IDLE;
      mstrd_req   <= 1'b0;
      mstwr_req   <= 1'b0;
      mst_lock    <= 1'b0;
      mst_addr    <= '0;
      mst_be      <= '0;
      busy        <= 1'b0;
      clr_go      <= 1'b0;
      set_done    <= 1'b0;
      set_error   <= 1'b0;
      set_timeout <= 1'b0;
    end
    else
    begin
      // request and pulses drop unless a state drives them
      mstrd_req   <= 1'b0;
      mstwr_req   <= 1'b0;
      mst_lock    <= 1'b0;
      mst_addr    <= '0;
      mst_be      <= '0;
      clr_go      <= 1'b0;
      set_done    <= 1'b0;
      set_error   <= 1'b0;
      set_timeout <= 1'b0;
      busy        <= 1'b1;

      case (state)
        CMD_IDLE:
        begin
          if (go)
          begin
            state  <= CMD_RUN;
            clr_go <= 1'b1;
          end
          else
            busy <= 1'b0;
        end
        CMD_RUN:
        begin
          if (mst_cmdack && !mst_cmplt)
            state <= CMD_WAIT_FOR_DATA;
          else if (mst_cmplt)
          begin
            state <= CMD_DONE;
            // a timeout also counts as an error
            set_error   <= mst_cmd_timeout | mst_error;
            set_timeout <= mst_cmd_timeout;
          end
          else
          begin
            // hold the request until the bus takes it
            mstrd_req <= cntl_rd_req;
            mstwr_req <= cntl_wr_req;
            mst_lock  <= cntl_bus_lock;
            mst_addr  <= target_addr;
            mst_be    <= target_be;
          end
        end
        CMD_WAIT_FOR_DATA:
        begin
          // data phase latency is open ended
          if (mst_cmplt)
          begin
            state       <= CMD_DONE;
            set_error   <= mst_cmd_timeout | mst_error;
            set_timeout <= mst_cmd_timeout;
          end
        end
        CMD_DONE:
        begin
          state    <= CMD_IDLE;
          set_done <= 1'b1;
          busy     <= 1'b0;
        end
        default:
        begin
          state <= CMD_IDLE;
          busy  <= 1'b0;
        end
      endcase
    end
  end

  // requests only ever leave while the command is outstanding
  a_req_in_run : assert property (
    @(posedge Bus2IP_Clk) disable iff (!rst_n)
    (mstrd_req || mstwr_req) |-> state == CMD_RUN);

  // done is reported once, on the way out of CMD_DONE
  a_done_after_done_state : assert property (
    @(posedge Bus2IP_Clk) disable iff (!rst_n)
    set_done |-> $past(state) == CMD_DONE);

endmodule

`default_nettype wire

/* master/master_regs.sv */
`default_nettype none

module master_regs
  import dma_pkg::*;
(
  input  logic                    Bus2IP_Clk,
  input  logic                    rst_n,
  input  logic [NUM_MST_WORD-1:0] wr_sel,
  input  logic [NUM_MST_WORD-1:0] rd_sel,
  input  be_t                     wr_be,
  input  word_t                   wr_data,
  output word_t                   rd_data,
  input  logic                    busy,
  input  logic                    clr_go,
  input  logic                    set_done,
  input  logic                    set_error,
  input  logic                    set_timeout,
  output logic                    go,
  output logic                    cntl_rd_req,
  output logic                    cntl_wr_req,
  output logic                    cntl_bus_lock,
  output addr_t                   target_addr,
  output be_t                     target_be
);

  // bit offset of the status and go bytes inside a bus word
  localparam int STAT_LSB = (STAT_BYTE % BE_WIDTH) * 8;
  localparam int GO_LSB   = (GO_BYTE_LANE % BE_WIDTH) * 8;

  // flattened byte bank where reserved bytes never leave zero
  logic [7:0]              mst_reg [NUM_MST_BYTE];
  logic [NUM_MST_BYTE-1:0] byte_we;
  logic                    go_q;

  // ----------------------------------------------------------
  // per byte write enables
  // ----------------------------------------------------------
  // word select msb is word 0 and be picks the lane within the word
  always_comb
  begin
    for (int b = 0; b < NUM_MST_BYTE; b++)
      byte_we[b] = $onehot(wr_sel) & wr_sel[NUM_MST_WORD-1-b/BE_WIDTH]
                   & wr_be[b%BE_WIDTH];
  end

  always_ff @(posedge Bus2IP_Clk)
  begin
    if (!rst_n)
    begin
      for (int b = 0; b < NUM_MST_BYTE; b++)
        mst_reg[b] <= '0;
    end
    else
    begin
      // control, address, be and length bytes
      for (int b = 0; b < NUM_MST_BYTE; b++)
        if (MST_STORE_MASK[b] && byte_we[b])
        begin
          if (b == LEN_HI_BYTE)
            // only a 12 bit length is kept
            mst_reg[b] <= {4'h0, wr_data[(b%BE_WIDTH)*8 +: 4]};
          else
            mst_reg[b] <= wr_data[(b%BE_WIDTH)*8 +: 8];
        end

      mst_reg[STAT_BYTE][STAT_BUSY_BIT] <= busy;

      // software write wins over the sticky set pulses
      if (byte_we[STAT_BYTE])
      begin
        mst_reg[STAT_BYTE][STAT_DONE_BIT]    <= wr_data[STAT_LSB + STAT_DONE_BIT];
        mst_reg[STAT_BYTE][STAT_ERROR_BIT]   <= wr_data[STAT_LSB + STAT_ERROR_BIT];
        mst_reg[STAT_BYTE][STAT_TIMEOUT_BIT] <= wr_data[STAT_LSB + STAT_TIMEOUT_BIT];
      end
      else
      begin
        mst_reg[STAT_BYTE][STAT_DONE_BIT]    <= mst_reg[STAT_BYTE][STAT_DONE_BIT] | set_done;
        mst_reg[STAT_BYTE][STAT_ERROR_BIT]   <= mst_reg[STAT_BYTE][STAT_ERROR_BIT] | set_error;
        mst_reg[STAT_BYTE][STAT_TIMEOUT_BIT] <=
          mst_reg[STAT_BYTE][STAT_TIMEOUT_BIT] | set_timeout;
      end
    end
  end

  // ----------------------------------------------------------
  // write only go port
  // ----------------------------------------------------------
  // armed by the key while idle and dropped once the fsm takes it
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (!rst_n || clr_go)
      go_q <= 1'b0;
    else if (!busy && byte_we[GO_BYTE_LANE] && wr_data[GO_LSB +: 8] == GO_DATA_KEY)
      go_q <= 1'b1;
  end

  assign go = go_q;

  // byte 15 holds nothing so go reads back zero
  always_comb
  begin
    rd_data = '0;
    if ($onehot(rd_sel))
    begin
      for (int w = 0; w < NUM_MST_WORD; w++)
        if (rd_sel[NUM_MST_WORD-1-w])
          for (int k = 0; k < BE_WIDTH; k++)
            rd_data[k*8 +: 8] = mst_reg[w*BE_WIDTH + k];
    end
  end

  // fields handed to the command fsm
  assign cntl_rd_req   = mst_reg[CNTL_BYTE][CNTL_RD_REQ_BIT];
  assign cntl_wr_req   = mst_reg[CNTL_BYTE][CNTL_WR_REQ_BIT];
  assign cntl_bus_lock = mst_reg[CNTL_BYTE][CNTL_BUS_LOCK_BIT];
  assign target_addr   = {mst_reg[ADDR_BYTE+3], mst_reg[ADDR_BYTE+2],
                          mst_reg[ADDR_BYTE+1], mst_reg[ADDR_BYTE]};
  // top nibble of the 16 bit be register
  assign target_be     = mst_reg[BE_BYTE+1][7:4];

  // the fsm is still idle on the edge after go is armed
  a_go_only_idle : assert property (
    @(posedge Bus2IP_Clk) disable iff (!rst_n)
    $rose(go) |-> !busy);

endmodule

`default_nettype wire

/* hdl/slave_regs.sv */
`default_nettype none

module slave_regs
  import dma_pkg::*;
(
  input  logic                   Bus2IP_Clk,
  input  logic                   rst_n,
  input  logic [NUM_SLV_REG-1:0] wr_sel,
  input  logic [NUM_SLV_REG-1:0] rd_sel,
  input  word_t                  wr_data,
  output word_t                  rd_data
);

  // scratch storage, software view only
  word_t slv_reg [NUM_SLV_REG];

  // ----------------------------------------------------------
  // write decode
  // ----------------------------------------------------------
  // msb of the select picks register 0
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_SLV_REG; i++)
        slv_reg[i] <= '0;
    end
    else if ($onehot(wr_sel))
    begin
      for (int i = 0; i < NUM_SLV_REG; i++)
        if (wr_sel[NUM_SLV_REG-1-i])
          slv_reg[i] <= wr_data;
    end
  end

  // ----------------------------------------------------------
  // read mux
  // ----------------------------------------------------------
  // anything other than a single select bit reads as zero
  always_comb
  begin
    rd_data = '0;
    if ($onehot(rd_sel))
    begin
      for (int i = 0; i < NUM_SLV_REG; i++)
        if (rd_sel[NUM_SLV_REG-1-i])
          rd_data = slv_reg[i];
    end
  end

  // bus never strobes read and write enables together
  a_no_rd_wr_overlap : assert property (
    @(posedge Bus2IP_Clk) disable iff (!rst_n)
    !((|rd_sel) && (|wr_sel)));

endmodule

`default_nettype wire

/* common/dma_pkg.sv */
`default_nettype none

package dma_pkg;

  // ----------------------------------------------------------
  // bus widths
  // ----------------------------------------------------------
  localparam int DWIDTH   = 32;
  localparam int AWIDTH   = 32;
  localparam int BE_WIDTH = DWIDTH / 8;

  // slave registers in ce bits 7..0, master words in ce bits 11..8
  localparam int NUM_SLV_REG  = 8;
  localparam int NUM_MST_WORD = 4;
  localparam int NUM_CE       = NUM_SLV_REG + NUM_MST_WORD;
  localparam int NUM_MST_BYTE = NUM_MST_WORD * BE_WIDTH;

  // ----------------------------------------------------------
  // master register map, byte offsets
  // ----------------------------------------------------------
  localparam int CNTL_BYTE    = 0;
  localparam int STAT_BYTE    = 1;
  localparam int ADDR_BYTE    = 4;
  localparam int BE_BYTE      = 8;
  localparam int LEN_BYTE     = 12;
  localparam int LEN_HI_BYTE  = LEN_BYTE + 1;
  localparam int GO_BYTE_LANE = 15;

  // bytes backed by plain storage: 0, 4..9, 12, 13
  localparam logic [NUM_MST_BYTE-1:0] MST_STORE_MASK = 16'h33F1;

  // only this value on the go byte starts a transfer
  localparam logic [7:0] GO_DATA_KEY = 8'h0A;

  // control byte bits
  localparam int CNTL_RD_REQ_BIT   = 0;
  localparam int CNTL_WR_REQ_BIT   = 1;
  localparam int CNTL_BUS_LOCK_BIT = 2;

  // status byte bits
  localparam int STAT_DONE_BIT    = 0;
  localparam int STAT_BUSY_BIT    = 1;
  localparam int STAT_ERROR_BIT   = 2;
  localparam int STAT_TIMEOUT_BIT = 3;

  localparam int FIFO_DEPTH_DEFAULT = 16;

  typedef logic [DWIDTH-1:0]   word_t;
  typedef logic [AWIDTH-1:0]   addr_t;
  typedef logic [BE_WIDTH-1:0] be_t;
  typedef logic [NUM_CE-1:0]   ce_t;

  // master command interface states
  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_RUN,
    CMD_WAIT_FOR_DATA,
    CMD_DONE
  } cmd_state_e;

endpackage

`default_nettype wire
